// ==== source/sys_consts.svh ====
`ifndef SYS_CONSTS_SVH
`define SYS_CONSTS_SVH

// Machine word width
`define XLEN 64

// Machine-mode CSR addresses
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343

// mstatus bit positions
`define MS_MIE    3
`define MS_MPIE   7
`define MS_MPP_LO 11
`define MS_MPP_HI 12

// Flow control sizing
`define REQ_DEPTH    4      // Request queue entries, upstream starts with this many credits
`define RESP_CREDITS 2      // Downstream buffer slots

// MXL = 2 (RV64), extensions I, M, S and U
`define MISA_RESET 64'h8000_0000_0014_1100

`endif

// ==== source/sys_pkg.sv ====
`default_nettype none

`include "sys_consts.svh"

package sys_pkg;

    // ************************************************************************
    // Privilege and operation encodings
    // ************************************************************************

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_t;

    // One-hot, all zero for no operation
    typedef struct packed {
        logic csrrw;
        logic csrrs;
        logic csrrc;
        logic ecall;
        logic ebreak;
        logic mret;
    } sys_op_t;

    localparam sys_op_t SYS_OP_NONE = '0;

    // ************************************************************************
    // Payloads
    // ************************************************************************

    typedef struct packed {
        logic [31:0]      instr;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_data;
        logic [3:0]       tag;
    } sys_req_t;

    typedef struct packed {
        sys_op_t          op;
        logic [11:0]      csr_addr;
        logic [`XLEN-1:0] wdata;     // rs1_data or zero-extended zimm
        logic [`XLEN-1:0] pc;
        logic [3:0]       tag;
    } sys_dec_t;

    typedef struct packed {
        logic [3:0]       tag;
        logic [`XLEN-1:0] rd_data;   // Old CSR value
        logic             redirect;
        logic [`XLEN-1:0] redirect_pc;
    } sys_resp_t;

endpackage

`default_nettype wire

// ==== source/credit_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_consts.svh"

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `REQ_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;           // Entries visible to the reader
    logic          push_q;          // Written last edge, not yet counted

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        logic [PW-1:0] nxt;
        nxt = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    // Storage
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // A pushed entry reaches the head one cycle after its write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            push_q <= 1'b0;
        end else begin
            push_q <= push;
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CW'(push_q) - CW'(pop);
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

// ==== source/sys_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_consts.svh"

module sys_decoder (
    input  sys_pkg::sys_req_t req,
    output sys_pkg::sys_dec_t dec
);

    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [11:0] IMM_ECALL  = 12'h000;
    localparam logic [11:0] IMM_EBREAK = 12'h001;
    localparam logic [11:0] IMM_MRET   = 12'h302;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  zimm;             // rs1 field, immediate for csrr*i
    logic [11:0] imm;              // CSR address or priv function

    assign opcode = req.instr[6:0];
    assign funct3 = req.instr[14:12];
    assign zimm   = req.instr[19:15];
    assign imm    = req.instr[31:20];

    always_comb begin
        dec.op = sys_pkg::SYS_OP_NONE;
        if (opcode == OPC_SYSTEM) begin
            case (funct3)
                3'b000: begin
                    case (imm)
                        IMM_ECALL:  dec.op.ecall  = 1'b1;
                        IMM_EBREAK: dec.op.ebreak = 1'b1;
                        IMM_MRET:   dec.op.mret   = 1'b1;
                        default:    ;
                    endcase
                end
                3'b001, 3'b101: dec.op.csrrw = 1'b1;
                3'b010, 3'b110: dec.op.csrrs = 1'b1;
                3'b011, 3'b111: dec.op.csrrc = 1'b1;
                default:        ;              // 3'b100 is reserved
            endcase
        end
    end

    // Immediate forms have funct3[2] set
    assign dec.wdata    = funct3[2] ? `XLEN'(zimm) : req.rs1_data;
    assign dec.csr_addr = imm;
    assign dec.pc       = req.pc;
    assign dec.tag      = req.tag;

endmodule

`default_nettype wire

// ==== source/sys_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_consts.svh"

module sys_issue (
    input  logic clk,
    input  logic rst_n,
    input  logic not_empty,
    input  logic resp_credit,
    output logic pop,
    output logic req_credit
);

    localparam int CW = $clog2(`RESP_CREDITS + 1);

    // Free slots in the downstream buffer
    logic [CW-1:0] credits;

    // Work waiting and somewhere to put the response
    assign pop = not_empty && (credits != '0);

    // ************************************************************************
    // Credit bookkeeping, both directions
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits    <= CW'(`RESP_CREDITS);
            req_credit <= 1'b0;
        end else begin
            // Spend on pop, refill on return, both may land together
            credits    <= credits - CW'(pop) + CW'(resp_credit);
            req_credit <= pop;          // One queue slot freed
        end
    end

endmodule

`default_nettype wire

// ==== source/csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_consts.svh"

module csr_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exec,
    input  sys_pkg::sys_dec_t  dec,
    output logic               resp_valid,
    output sys_pkg::sys_resp_t resp
);

    // Writable mstatus bits
    localparam logic [`XLEN-1:0] MSTATUS_MASK = (`XLEN'(1) << `MS_MIE)
                                              | (`XLEN'(1) << `MS_MPIE)
                                              | (`XLEN'(3) << `MS_MPP_LO);

    localparam logic [`XLEN-1:0] CAUSE_BREAKPOINT = `XLEN'(3);
    localparam logic [`XLEN-1:0] CAUSE_ECALL_U    = `XLEN'(8);
    localparam logic [`XLEN-1:0] CAUSE_ECALL_S    = `XLEN'(9);
    localparam logic [`XLEN-1:0] CAUSE_ECALL_M    = `XLEN'(11);

    sys_pkg::priv_t   priv;
    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mtval;
    logic [`XLEN-1:0] mscratch;

    logic [`XLEN-1:0] csr_rdata;
    logic [`XLEN-1:0] csr_wdata;
    logic [`XLEN-1:0] ecall_cause;
    logic [`XLEN-1:0] mstatus_trap;
    logic [`XLEN-1:0] mstatus_mret;
    logic             is_csr;
    logic             is_trap;

    assign is_csr  = dec.op.csrrw | dec.op.csrrs | dec.op.csrrc;
    assign is_trap = dec.op.ecall | dec.op.ebreak;

    // ************************************************************************
    // Read mux and next values
    // ************************************************************************

    always_comb begin
        case (dec.csr_addr)
            `CSR_MSTATUS:  csr_rdata = mstatus;
            `CSR_MISA:     csr_rdata = `MISA_RESET;   // Read-only
            `CSR_MTVEC:    csr_rdata = mtvec;
            `CSR_MSCRATCH: csr_rdata = mscratch;
            `CSR_MEPC:     csr_rdata = mepc;
            `CSR_MCAUSE:   csr_rdata = mcause;
            `CSR_MTVAL:    csr_rdata = mtval;
            default:       csr_rdata = '0;
        endcase
    end

    always_comb begin
        if (dec.op.csrrw)
            csr_wdata = dec.wdata;
        else if (dec.op.csrrs)
            csr_wdata = csr_rdata | dec.wdata;
        else
            csr_wdata = csr_rdata & ~dec.wdata;
    end

    always_comb begin
        case (priv)
            sys_pkg::PRIV_U: ecall_cause = CAUSE_ECALL_U;
            sys_pkg::PRIV_S: ecall_cause = CAUSE_ECALL_S;
            default:         ecall_cause = CAUSE_ECALL_M;
        endcase
    end

    // Interrupt-enable stack push on trap, pop on mret
    always_comb begin
        mstatus_trap                          = mstatus;
        mstatus_trap[`MS_MPIE]                = mstatus[`MS_MIE];
        mstatus_trap[`MS_MIE]                 = 1'b0;
        mstatus_trap[`MS_MPP_HI:`MS_MPP_LO]   = priv;

        mstatus_mret                          = mstatus;
        mstatus_mret[`MS_MIE]                 = mstatus[`MS_MPIE];
        mstatus_mret[`MS_MPIE]                = 1'b1;
        mstatus_mret[`MS_MPP_HI:`MS_MPP_LO]   = sys_pkg::PRIV_U;
    end

    // ************************************************************************
    // Architectural state
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv       <= sys_pkg::PRIV_M;
            mstatus    <= '0;
            mtvec      <= '0;
            mepc       <= '0;
            mcause     <= '0;
            mtval      <= '0;
            mscratch   <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= exec;
            if (exec && is_trap) begin
                mepc    <= dec.pc;
                mcause  <= dec.op.ebreak ? CAUSE_BREAKPOINT : ecall_cause;
                mtval   <= dec.op.ebreak ? dec.pc : '0;
                mstatus <= mstatus_trap;
                priv    <= sys_pkg::PRIV_M;
            end else if (exec && dec.op.mret) begin
                mstatus <= mstatus_mret;
                priv    <= sys_pkg::priv_t'(mstatus[`MS_MPP_HI:`MS_MPP_LO]);
            end else if (exec && is_csr) begin
                case (dec.csr_addr)
                    `CSR_MSTATUS:  mstatus  <= csr_wdata & MSTATUS_MASK;
                    `CSR_MTVEC:    mtvec    <= {csr_wdata[`XLEN-1:2], 2'b00};
                    `CSR_MEPC:     mepc     <= {csr_wdata[`XLEN-1:2], 2'b00};
                    `CSR_MSCRATCH: mscratch <= csr_wdata;
                    `CSR_MCAUSE:   mcause   <= csr_wdata;
                    `CSR_MTVAL:    mtval    <= csr_wdata;
                    default:       ;          // misa and unmapped addresses
                endcase
            end
        end
    end

    // Response payload, qualified by resp_valid
    always_ff @(posedge clk) begin
        if (exec) begin
            resp.tag         <= dec.tag;
            resp.rd_data     <= is_csr ? csr_rdata : '0;
            resp.redirect    <= is_trap | dec.op.mret;
            resp.redirect_pc <= is_trap ? mtvec : (dec.op.mret ? mepc : '0);
        end
    end

endmodule

`default_nettype wire

// ==== source/sys_unit_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sys_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  sys_pkg::sys_req_t  req,
    output logic               req_credit,
    output logic               resp_valid,
    output sys_pkg::sys_resp_t resp,
    input  logic               resp_credit
);

    sys_pkg::sys_req_t head;        // Oldest queued request
    sys_pkg::sys_dec_t dec;
    logic              not_empty;
    logic              pop;

    // Request queue, sized to the upstream credit count
    credit_fifo #(
        .payload_t (sys_pkg::sys_req_t)
    ) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (req_valid),
        .push_data (req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty)
    );

    sys_decoder u_decoder (
        .req (head),
        .dec (dec)
    );

    sys_issue u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .not_empty   (not_empty),
        .resp_credit (resp_credit),
        .pop         (pop),
        .req_credit  (req_credit)
    );

    // Executes the head on pop
    csr_unit u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec       (pop),
        .dec        (dec),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// ==== bench/sys_unit_tests.svh ====
`ifndef SYS_UNIT_TESTS_SVH
`define SYS_UNIT_TESTS_SVH

function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                          input logic [4:0] src);
    return {addr, src, f3, 5'd1, 7'h73};            // rd is x1
endfunction

task automatic csr_write(input logic [11:0] addr, input logic [63:0] val);
    sys_pkg::sys_resp_t e;
    send_req(csr_instr(3'b001, addr, 5'd2), 64'h1000, val, e);
endtask

// csrrs with x0 leaves the CSR alone
task automatic read_expect(input logic [11:0] addr, input logic [63:0] value, input string what);
    sys_pkg::sys_resp_t e;
    send_req(csr_instr(3'b010, addr, 5'd0), 64'h1004, 64'd0, e);
    check_value(what, e.rd_data, value);
endtask

task automatic test_reset_values();
    lat_check = 1'b1;                               // Idle unit, fixed latency
    read_expect(`CSR_MISA, `MISA_RESET, "misa after reset");
    drain();
    read_expect(`CSR_MSTATUS, 64'd0, "mstatus after reset");
    drain();
    read_expect(`CSR_MTVEC, 64'd0, "mtvec after reset");
    drain();
    lat_check = 1'b0;
endtask

task automatic test_csr_ops();
    sys_pkg::sys_resp_t e;
    logic [2:0] forms [6] = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    foreach (forms[i]) begin
        send_req(csr_instr(forms[i], `CSR_MSCRATCH, 5'($urandom)), 64'h1100,
                 {$urandom, $urandom}, e);
        send_req(csr_instr(3'b010, `CSR_MSCRATCH, 5'd0), 64'h1104, 64'd0, e);
    end
    csr_write(`CSR_MTVEC, 64'h8000_0107);
    read_expect(`CSR_MTVEC, 64'h8000_0104, "mtvec low bits");
    csr_write(`CSR_MEPC, 64'h3003);
    read_expect(`CSR_MEPC, 64'h3000, "mepc low bits");
    csr_write(`CSR_MSTATUS, '1);
    read_expect(`CSR_MSTATUS, 64'h1888, "mstatus mask");
    csr_write(`CSR_MISA, 64'd0);
    read_expect(`CSR_MISA, `MISA_RESET, "misa read-only");
    csr_write(`CSR_MSTATUS, 64'd0);
    drain();
endtask

task automatic test_traps();
    sys_pkg::sys_resp_t e;
    csr_write(`CSR_MTVEC, 64'h8000_0200);
    csr_write(`CSR_MSTATUS, 64'h8);                 // MIE set
    send_req(INSTR_ECALL, 64'h2000, 64'd0, e);
    check_value("ecall redirect pc", e.redirect_pc, 64'h8000_0200);
    read_expect(`CSR_MCAUSE, 64'd11, "mcause ecall from M");
    read_expect(`CSR_MEPC, 64'h2000, "mepc after ecall");
    read_expect(`CSR_MSTATUS, 64'h1880, "mstatus after ecall");
    send_req(INSTR_EBREAK, 64'h2104, 64'd0, e);
    read_expect(`CSR_MCAUSE, 64'd3, "mcause ebreak");
    read_expect(`CSR_MTVAL, 64'h2104, "mtval ebreak");
    drain();
endtask

task automatic test_mret();
    sys_pkg::sys_resp_t e;
    csr_write(`CSR_MSTATUS, 64'h0800);              // MPP = S
    csr_write(`CSR_MEPC, 64'h3000);
    send_req(INSTR_MRET, 64'h4000, 64'd0, e);
    check_value("mret redirect pc", e.redirect_pc, 64'h3000);
    send_req(INSTR_ECALL, 64'h3000, 64'd0, e);
    read_expect(`CSR_MCAUSE, 64'd9, "mcause ecall from S");
    send_req(INSTR_ECALL, 64'h3008, 64'd0, e);      // Handler side, back in M
    read_expect(`CSR_MSTATUS, 64'h1800, "MPP after ecall from M");
    csr_write(`CSR_MSTATUS, 64'd0);                 // MPP = U
    csr_write(`CSR_MEPC, 64'h5000);
    send_req(INSTR_MRET, 64'h4100, 64'd0, e);
    send_req(INSTR_ECALL, 64'h5000, 64'd0, e);
    read_expect(`CSR_MCAUSE, 64'd8, "mcause ecall from U");
    drain();
endtask

task automatic test_burst();
    sys_pkg::sys_resp_t e;
    stall_en = 1'b1;                                // Slow credit returns
    for (int i = 0; i < 8; i++) begin
        if (i % 2 == 0)
            send_req(csr_instr(3'b001, `CSR_MSCRATCH, 5'd3), 64'h6000 + 64'(4 * i),
                     {$urandom, $urandom}, e);
        else
            send_req(csr_instr(3'b010, `CSR_MSCRATCH, 5'd0), 64'h6000 + 64'(4 * i),
                     64'd0, e);
    end
    drain();
    stall_en = 1'b0;
endtask

`endif

// ==== bench/sys_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_consts.svh"

module sys_unit_tb;

    localparam int CLK_PERIOD = 4;
    localparam int WAIT_LIMIT = 200;                // Cycles allowed for a drain
    localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
    localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
    localparam logic [63:0] MSTATUS_BITS = (64'd1 << `MS_MIE) | (64'd1 << `MS_MPIE)
                                         | (64'd3 << `MS_MPP_LO);

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req_valid;
    sys_pkg::sys_req_t  req;
    logic               req_credit;
    logic               resp_valid;
    sys_pkg::sys_resp_t resp;
    logic               resp_credit;

    // Scoreboard with one entry per request in flight
    sys_pkg::sys_resp_t exp_q[$];
    int                 sent_at_q[$];
    bit                 lat_q[$];

    int         cycle = 0;
    int         sent = 0;
    int         credit_ret = 0;                     // req_credit pulses seen
    int         resp_seen = 0;
    int         resp_returned = 0;                  // resp_credit pulses driven
    int         err_count = 0;
    int         fail_count = 0;
    bit         lat_check = 1'b0;
    bit         stall_en = 1'b0;
    logic [3:0] next_tag = 4'd0;

    // Reference CSR state
    logic [1:0]  m_priv = 2'b11;
    logic [63:0] m_mstatus = '0;
    logic [63:0] m_mtvec = '0;
    logic [63:0] m_mepc = '0;
    logic [63:0] m_mcause = '0;
    logic [63:0] m_mtval = '0;
    logic [63:0] m_mscratch = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sys_unit_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0d ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("FAILURE at %0d ns: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d other failures", err_count, fail_count);
    endtask

    // ************************************************************************
    // Reference model of the CSR rules
    // ************************************************************************

    function automatic logic [63:0] model_read(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS:  return m_mstatus;
            `CSR_MISA:     return `MISA_RESET;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MEPC:     return m_mepc;
            `CSR_MCAUSE:   return m_mcause;
            `CSR_MTVAL:    return m_mtval;
            default:       return '0;
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [63:0] val);
        case (addr)
            `CSR_MSTATUS:  m_mstatus = val & MSTATUS_BITS;
            `CSR_MTVEC:    m_mtvec = val & ~64'h3;
            `CSR_MEPC:     m_mepc = val & ~64'h3;
            `CSR_MSCRATCH: m_mscratch = val;
            `CSR_MCAUSE:   m_mcause = val;
            `CSR_MTVAL:    m_mtval = val;
            default:       ;                        // misa and unmapped
        endcase
    endtask

    task automatic predict(input sys_pkg::sys_req_t r, output sys_pkg::sys_resp_t e);
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [63:0] old;
        logic [63:0] wv;
        bit          sys;
        f3    = r.instr[14:12];
        addr  = r.instr[31:20];
        sys   = (r.instr[6:0] == 7'h73);
        e     = '0;
        e.tag = r.tag;
        if (sys && f3 != 3'b000 && f3 != 3'b100) begin
            old = model_read(addr);
            wv  = f3[2] ? {59'd0, r.instr[19:15]} : r.rs1_data;
            case (f3[1:0])
                2'b01:   model_write(addr, wv);
                2'b10:   model_write(addr, old | wv);
                default: model_write(addr, old & ~wv);
            endcase
            e.rd_data = old;
        end else if (sys && f3 == 3'b000 && (addr == 12'h000 || addr == 12'h001)) begin
            e.redirect    = 1'b1;
            e.redirect_pc = m_mtvec;
            m_mepc        = r.pc;
            m_mtval       = addr[0] ? r.pc : 64'd0;
            case (m_priv)
                2'b00:   m_mcause = 64'd8;
                2'b01:   m_mcause = 64'd9;
                default: m_mcause = 64'd11;
            endcase
            if (addr[0])
                m_mcause = 64'd3;                   // Breakpoint
            m_mstatus[`MS_MPIE]              = m_mstatus[`MS_MIE];
            m_mstatus[`MS_MIE]               = 1'b0;
            m_mstatus[`MS_MPP_HI:`MS_MPP_LO] = m_priv;
            m_priv                           = 2'b11;
        end else if (sys && f3 == 3'b000 && addr == 12'h302) begin
            e.redirect    = 1'b1;
            e.redirect_pc = m_mepc;
            m_priv        = m_mstatus[`MS_MPP_HI:`MS_MPP_LO];
            m_mstatus[`MS_MIE]               = m_mstatus[`MS_MPIE];
            m_mstatus[`MS_MPIE]              = 1'b1;
            m_mstatus[`MS_MPP_HI:`MS_MPP_LO] = 2'b00;
        end
    endtask

    // ************************************************************************
    // Request driver and drain
    // ************************************************************************

    task automatic send_req(input logic [31:0] instr, input logic [63:0] pc,
                            input logic [63:0] rs1_data, output sys_pkg::sys_resp_t e);
        sys_pkg::sys_req_t r;
        @(negedge clk);
        req_valid = 1'b0;
        while (`REQ_DEPTH - sent + credit_ret == 0)  // No upstream credit left
            @(negedge clk);
        r.instr    = instr;
        r.pc       = pc;
        r.rs1_data = rs1_data;
        r.tag      = next_tag;
        next_tag   = next_tag + 4'd1;
        predict(r, e);
        exp_q.push_back(e);
        sent_at_q.push_back(cycle + 1);             // Edge that samples it
        lat_q.push_back(lat_check);
        req       = r;
        req_valid = 1'b1;
        sent++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while ((resp_seen < sent || resp_returned < resp_seen || credit_ret < sent)
               && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (resp_seen < sent)
            report_failure($sformatf("%0d responses never arrived", sent - resp_seen));
        else if (credit_ret < sent)
            report_failure($sformatf("%0d request credits never returned", sent - credit_ret));
    endtask

    `include "sys_unit_tests.svh"

    initial begin
        void'($urandom(32'h5995));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        fork
            begin : monitor
                sys_pkg::sys_resp_t exp;
                int                 sent_at;
                bit                 lat;
                forever begin
                    @(posedge clk);
                    if (req_credit) begin
                        credit_ret++;
                        if (credit_ret > sent)
                            report_failure("request credit returned with nothing in flight");
                    end
                    if (resp_valid) begin
                        resp_seen++;
                        if (resp_seen - resp_returned > `RESP_CREDITS)
                            report_failure("response sent without a free response credit");
                        if (exp_q.size() == 0) begin
                            report_failure("response arrived with no request pending");
                        end else begin
                            exp     = exp_q.pop_front();
                            sent_at = sent_at_q.pop_front();
                            lat     = lat_q.pop_front();
                            check_value("tag", 64'(resp.tag), 64'(exp.tag));
                            check_value("rd_data", resp.rd_data, exp.rd_data);
                            check_value("redirect", 64'(resp.redirect), 64'(exp.redirect));
                            check_value("redirect_pc", resp.redirect_pc, exp.redirect_pc);
                            if (lat)
                                check_value("latency", 64'(cycle - sent_at), 64'd2);
                        end
                    end
                    // A credit comes back with the response of its popped entry
                    if (credit_ret > resp_seen)
                        report_failure("request credit returned before its entry was popped");
                    cycle++;
                end
            end
            begin : consumer
                int delay;
                resp_credit = 1'b0;
                forever begin
                    @(negedge clk);
                    resp_credit = 1'b0;
                    if (resp_returned < resp_seen) begin
                        delay = stall_en ? int'($urandom % 7) : 0;
                        repeat (delay) @(negedge clk);
                        resp_credit = 1'b1;
                        resp_returned++;
                    end
                end
            end
            begin : watchdog
                while ($time < time'(sent) * 400 * CLK_PERIOD + 2000)
                    @(negedge clk);
                report_failure("watchdog timeout, the run did not finish");
                print_counts();
                $display("Verification failed");
                $finish;
            end
        join_none

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_values();
        test_csr_ops();
        test_traps();
        test_mret();
        test_burst();

        print_counts();
        if (err_count == 0 && fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
+incdir+bench
source/sys_pkg.sv
source/credit_fifo.sv
source/sys_decoder.sv
source/sys_issue.sv
source/csr_unit.sv
source/sys_unit_top.sv
bench/sys_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module sys_unit_tb \
    -f project.f \
    -o sys_unit_sim

./obj_dir/sys_unit_sim > sim.log
cat sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
